/* wb2axi_defs.svh */
// Wishbone to AXI bridge parameters
`ifndef WB2AXI_DEFS_SVH
`define WB2AXI_DEFS_SVH

// Byte address width on both buses
`define WB2AXI_ADDR_W 32

// Data width, one word per transaction
`define WB2AXI_DATA_W 32

// AXI transaction ID width
`define WB2AXI_ID_W 4

// Fixed IDs, one per direction
`define WB2AXI_WRITE_ID 0
`define WB2AXI_READ_ID 0

// Max transactions in flight before stall
`define WB2AXI_MAX_OUT 4

`endif

/* wb2axi_pkg.sv */
// Wishbone to AXI bridge types
`include "wb2axi_defs.svh"

package wb2axi_pkg;

	// Plain vector types
	typedef logic [`WB2AXI_ADDR_W-1:0] addr_t;
	typedef logic [`WB2AXI_DATA_W-1:0] data_t;
	typedef logic [`WB2AXI_DATA_W/8-1:0] sel_t;
	typedef logic [`WB2AXI_ID_W-1:0] axi_id_t;
	typedef logic [1:0] resp_t;
	// Needs to reach MAX_OUT itself, hence the +1
	typedef logic [$clog2(`WB2AXI_MAX_OUT+1)-1:0] outcnt_t;

	//////////////////////////////////////////////////
	// Bus payloads
	//////////////////////////////////////////////////

	// One Wishbone request
	typedef struct packed {
		logic we;
		addr_t addr;
		data_t data;
		sel_t sel;
	} wb_req_t;

	// Address channel, shared by AW and AR
	typedef struct packed {
		axi_id_t id;
		addr_t addr;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		logic lock;
		logic [3:0] cache;
		logic [2:0] prot;
		logic [3:0] qos;
	} axi_aw_t;

	// Write data beat
	typedef struct packed {
		data_t data;
		sel_t strb;
		logic last;
	} axi_w_t;

	// Write response
	typedef struct packed {
		axi_id_t id;
		resp_t resp;
	} axi_b_t;

	// Read data beat
	typedef struct packed {
		axi_id_t id;
		data_t data;
		resp_t resp;
		logic last;
	} axi_r_t;

	// Bridge control state
	typedef enum logic [1:0] {
		st_idle,
		st_write,
		st_read,
		st_flush
	} ctrl_state_e;

endpackage

/* wb2axi_ctrl.sv */
// Bridge control and stall
`timescale 1ns/1ps
`include "wb2axi_defs.svh"

module wb2axi_ctrl (
	input logic aclk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic req_accept,
	input logic issue_busy,
	input logic resp_done,
	output logic wb_stall,
	output logic discard
);
	import wb2axi_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_next;
	outcnt_t out_cnt;
	outcnt_t out_cnt_next;
	logic at_limit;
	logic dir_conflict;
	logic flushing;

	//////////////////////////////////////////////////
	// Outstanding count
	//////////////////////////////////////////////////

	// Up on accept, down on response beat
	// Both may happen in the same cycle
	always_comb begin
		out_cnt_next = out_cnt + outcnt_t'(req_accept) - outcnt_t'(resp_done);
	end

	//////////////////////////////////////////////////
	// Direction and flush FSM
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				// First request picks the direction
				if (req_accept) begin
					state_next = wb_we ? st_write : st_read;
				end
			end
			st_write, st_read: begin
				if (!wb_cyc) begin
					// Master gave up, drop what is still due
					state_next = (out_cnt_next != '0) ? st_flush : st_idle;
				end else if (out_cnt_next == '0) begin
					state_next = st_idle;
				end
			end
			st_flush: begin
				// Wait for the last stray response
				if (out_cnt_next == '0) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= st_idle;
			out_cnt <= '0;
		end else begin
			state <= state_next;
			out_cnt <= out_cnt_next;
		end
	end

	//////////////////////////////////////////////////
	// Stall
	//////////////////////////////////////////////////

	// No room for another transaction
	assign at_limit = (out_cnt == outcnt_t'(`WB2AXI_MAX_OUT));

	// Opposite direction while responses still due
	// Count nonzero means state holds the direction
	assign dir_conflict = wb_stb && (out_cnt != '0) && (wb_we != (state == st_write));

	assign flushing = (state == st_flush);

	assign wb_stall = issue_busy | at_limit | dir_conflict | flushing;

	// Also covers a response landing in the very cycle cyc drops
	assign discard = flushing | ~wb_cyc;

endmodule

/* axi_req_issue.sv */
// AXI request issue stage
`timescale 1ns/1ps
`include "wb2axi_defs.svh"

module axi_req_issue (
	input logic aclk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_stall,
	input wb2axi_pkg::wb_req_t wb_req,
	output logic req_accept,
	output logic issue_busy,
	output wb2axi_pkg::axi_aw_t aw,
	output logic aw_valid,
	input logic aw_ready,
	output wb2axi_pkg::axi_w_t w,
	output logic w_valid,
	input logic w_ready,
	output wb2axi_pkg::axi_aw_t ar,
	output logic ar_valid,
	input logic ar_ready
);
	import wb2axi_pkg::*;

	// Full AXI address beat from a plain address
	// Single beat, full width, FIXED, everything else zero
	function automatic axi_aw_t addr_beat(input addr_t addr, input axi_id_t id);
		axi_aw_t beat;
		beat.id = id;
		beat.addr = addr;
		beat.len = 8'd0;
		beat.size = 3'($clog2(`WB2AXI_DATA_W/8));
		beat.burst = 2'b00;
		beat.lock = 1'b0;
		beat.cache = 4'd0;
		beat.prot = 3'd0;
		beat.qos = 4'd0;
		return beat;
	endfunction

	// Standard Wishbone pipelined accept
	assign req_accept = wb_cyc & wb_stb & ~wb_stall;

	//////////////////////////////////////////////////
	// Valids
	//////////////////////////////////////////////////

	// Accept only happens while no valid is set,
	// so load and handshake never collide
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			ar_valid <= 1'b0;
		end else if (req_accept) begin
			aw_valid <= wb_req.we;
			w_valid <= wb_req.we;
			ar_valid <= ~wb_req.we;
		end else begin
			// Each channel drops on its own handshake
			if (aw_valid && aw_ready) begin
				aw_valid <= 1'b0;
			end
			if (w_valid && w_ready) begin
				w_valid <= 1'b0;
			end
			if (ar_valid && ar_ready) begin
				ar_valid <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Payloads
	//////////////////////////////////////////////////

	// Loaded once per accept, stable while valid
	always_ff @(posedge aclk) begin
		if (req_accept) begin
			if (wb_req.we) begin
				aw <= addr_beat(wb_req.addr, axi_id_t'(`WB2AXI_WRITE_ID));
				w.data <= wb_req.data;
				w.strb <= wb_req.sel;
				w.last <= 1'b1;
			end else begin
				ar <= addr_beat(wb_req.addr, axi_id_t'(`WB2AXI_READ_ID));
			end
		end
	end

	// Busy until AW and W both went through (or AR)
	assign issue_busy = aw_valid | w_valid | ar_valid;

endmodule

/* axi_resp_return.sv */
// AXI response return stage
`timescale 1ns/1ps

module axi_resp_return (
	input logic aclk,
	input logic rst_n,
	input logic discard,
	input wb2axi_pkg::axi_b_t b,
	input logic b_valid,
	output logic b_ready,
	input wb2axi_pkg::axi_r_t r,
	input logic r_valid,
	output logic r_ready,
	output logic resp_done,
	output logic wb_ack,
	output logic wb_err,
	output wb2axi_pkg::data_t wb_rdata
);
	import wb2axi_pkg::*;

	logic b_hs;
	logic r_hs;
	logic resp_hs;
	resp_t resp_code;

	// Wishbone has no way to stall an ack
	assign b_ready = 1'b1;
	assign r_ready = 1'b1;

	assign b_hs = b_valid & b_ready;
	assign r_hs = r_valid & r_ready;

	// Directions never mix, at most one of these per cycle
	assign resp_hs = b_hs | r_hs;
	assign resp_done = resp_hs;

	// Response code from whichever channel fired
	assign resp_code = b_hs ? b.resp : r.resp;

	//////////////////////////////////////////////////
	// Ack and err
	//////////////////////////////////////////////////

	// SLVERR and DECERR both have bit 1 set
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
		end else begin
			wb_ack <= resp_hs & ~discard & ~resp_code[1];
			wb_err <= resp_hs & ~discard & resp_code[1];
		end
	end

	// Read data, valid alongside ack
	always_ff @(posedge aclk) begin
		if (r_hs) begin
			wb_rdata <= r.data;
		end
	end

endmodule

/* wb2axi_top.sv */
// Wishbone to AXI bridge top
`timescale 1ns/1ps

module wb2axi_top (
	input logic aclk,
	input logic rst_n,
	// Wishbone pipelined slave side
	input logic wb_cyc,
	input logic wb_stb,
	input wb2axi_pkg::wb_req_t wb_req,
	output logic wb_stall,
	output logic wb_ack,
	output logic wb_err,
	output wb2axi_pkg::data_t wb_rdata,
	// AXI master side
	output wb2axi_pkg::axi_aw_t aw,
	output logic aw_valid,
	input logic aw_ready,
	output wb2axi_pkg::axi_w_t w,
	output logic w_valid,
	input logic w_ready,
	output wb2axi_pkg::axi_aw_t ar,
	output logic ar_valid,
	input logic ar_ready,
	input wb2axi_pkg::axi_b_t b,
	input logic b_valid,
	output logic b_ready,
	input wb2axi_pkg::axi_r_t r,
	input logic r_valid,
	output logic r_ready
);
	import wb2axi_pkg::*;

	logic req_accept;
	logic issue_busy;
	logic resp_done;
	logic discard;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	wb2axi_ctrl u_ctrl (
		.aclk(aclk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_req.we),
		.req_accept(req_accept),
		.issue_busy(issue_busy),
		.resp_done(resp_done),
		.wb_stall(wb_stall),
		.discard(discard)
	);

	//////////////////////////////////////////////////
	// Request and response paths
	//////////////////////////////////////////////////

	axi_req_issue u_issue (
		.aclk(aclk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_stall(wb_stall),
		.wb_req(wb_req),
		.req_accept(req_accept),
		.issue_busy(issue_busy),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready)
	);

	// Ready outputs come from here, always high
	axi_resp_return u_resp (
		.aclk(aclk),
		.rst_n(rst_n),
		.discard(discard),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.resp_done(resp_done),
		.wb_ack(wb_ack),
		.wb_err(wb_err),
		.wb_rdata(wb_rdata)
	);

endmodule

/* tb_clk_gen.sv */
// Testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_NS = 2
) (
	output logic clk
);

	// 4 ns period, starts low
	initial begin
		clk = 1'b0;
	end

	always #(HALF_NS) clk = ~clk;

endmodule

/* tb_axi_mem.sv */
// Behavioural AXI slave memory
`timescale 1ns/1ps
`include "wb2axi_defs.svh"

module tb_axi_mem (
	input logic clk,
	input logic rst_n,
	input logic hold_resp,
	input wb2axi_pkg::axi_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input wb2axi_pkg::axi_w_t w,
	input logic w_valid,
	output logic w_ready,
	input wb2axi_pkg::axi_aw_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output wb2axi_pkg::axi_b_t b,
	output logic b_valid,
	input logic b_ready,
	output wb2axi_pkg::axi_r_t r,
	output logic r_valid,
	input logic r_ready,
	output logic busy,
	output logic mix_err,
	output logic field_err
);
	import wb2axi_pkg::*;

	localparam addr_t ERR_BASE = 32'h8000_0000;

	// Sparse word storage keyed by aligned byte address
	data_t mem [addr_t];
	axi_aw_t aw_q[$];
	axi_w_t w_q[$];
	axi_b_t b_q[$];
	axi_r_t r_q[$];
	int b_due[$];
	int r_due[$];
	logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
	axi_aw_t aw_beat, ar_beat;
	axi_w_t w_beat;
	int cyc_cnt, wr_out, rd_out;

	// Unwritten words read back as a pattern of the full address
	function automatic data_t fill_word(input addr_t a);
		return {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
	endfunction

	// Expected ID and one 4-byte FIXED beat with all side fields zero
	function automatic logic bad_fields(input axi_aw_t a, input axi_id_t id);
		return (a.id != id) || (a.len != 8'd0) || (a.size != 3'd2) || (a.burst != 2'b00) ||
			a.lock || (a.cache != 4'd0) || (a.prot != 3'd0) || (a.qos != 4'd0);
	endfunction

	initial begin
		aw_ready = 1'b0;
		w_ready = 1'b0;
		ar_ready = 1'b0;
		b = '0;
		b_valid = 1'b0;
		r = '0;
		r_valid = 1'b0;
		busy = 1'b0;
		mix_err = 1'b0;
		field_err = 1'b0;
	end

	//////////////////////////////////////////////////
	// Slave model on the falling edge
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		addr_t k;
		data_t word;
		axi_b_t bb;
		axi_r_t rb;
		if (!rst_n) begin
			aw_q.delete();
			w_q.delete();
			b_q.delete();
			r_q.delete();
			b_due.delete();
			r_due.delete();
			{aw_hs, w_hs, ar_hs, b_hs, r_hs} = '0;
			{aw_ready, w_ready, ar_ready, b_valid, r_valid} = '0;
			cyc_cnt = 0;
			wr_out = 0;
			rd_out = 0;
			mix_err = 1'b0;
			field_err = 1'b0;
		end else begin
			// Handshakes that completed on the last rising edge
			if (aw_hs) begin
				aw_q.push_back(aw_beat);
				wr_out++;
			end
			if (w_hs) begin
				w_q.push_back(w_beat);
			end
			if (ar_hs) begin
				k = ar_beat.addr & ~addr_t'(3);
				rb.id = ar_beat.id;
				rb.last = 1'b1;
				rb.resp = (k >= ERR_BASE) ? 2'b10 : 2'b00;
				rb.data = (k >= ERR_BASE) ? '0 : (mem.exists(k) ? mem[k] : fill_word(k));
				r_q.push_back(rb);
				r_due.push_back(cyc_cnt + $urandom_range(0, 5));
				rd_out++;
			end
			if (b_hs) begin
				b_valid = 1'b0;
				wr_out--;
			end
			if (r_hs) begin
				r_valid = 1'b0;
				rd_out--;
			end
			// Commit once both AW and W are here
			// W may come first
			while (aw_q.size() != 0 && w_q.size() != 0) begin
				k = aw_q[0].addr & ~addr_t'(3);
				bb.id = aw_q[0].id;
				bb.resp = (k >= ERR_BASE) ? 2'b10 : 2'b00;
				// Error region keeps its old contents
				if (k < ERR_BASE) begin
					word = mem.exists(k) ? mem[k] : fill_word(k);
					for (int i = 0; i < 4; i++) begin
						if (w_q[0].strb[i]) begin
							word[8*i +: 8] = w_q[0].data[8*i +: 8];
						end
					end
					mem[k] = word;
				end
				void'(aw_q.pop_front());
				void'(w_q.pop_front());
				b_q.push_back(bb);
				b_due.push_back(cyc_cnt + $urandom_range(0, 5));
			end
			// In-order responses after their delay
			if (!b_valid && b_q.size() != 0 && !hold_resp && cyc_cnt >= b_due[0]) begin
				b = b_q.pop_front();
				void'(b_due.pop_front());
				b_valid = 1'b1;
			end
			if (!r_valid && r_q.size() != 0 && !hold_resp && cyc_cnt >= r_due[0]) begin
				r = r_q.pop_front();
				void'(r_due.pop_front());
				r_valid = 1'b1;
			end
			aw_ready = ($urandom_range(0, 3) != 0);
			w_ready = ($urandom_range(0, 3) != 0);
			ar_ready = ($urandom_range(0, 3) != 0);
			// Handshakes due on the next rising edge
			aw_hs = aw_valid && aw_ready;
			w_hs = w_valid && w_ready;
			ar_hs = ar_valid && ar_ready;
			b_hs = b_valid && b_ready;
			r_hs = r_valid && r_ready;
			aw_beat = aw;
			w_beat = w;
			ar_beat = ar;
			if ((aw_hs && bad_fields(aw, axi_id_t'(`WB2AXI_WRITE_ID))) ||
				(ar_hs && bad_fields(ar, axi_id_t'(`WB2AXI_READ_ID))) ||
				(w_hs && !w.last)) begin
				field_err = 1'b1;
			end
			// Sticky flag for a read and a write both in flight
			if ((wr_out != 0 || w_q.size() != 0) && rd_out != 0) begin
				mix_err = 1'b1;
			end
			busy = (wr_out != 0) || (rd_out != 0) || (w_q.size() != 0);
			cyc_cnt++;
		end
	end

endmodule

/* tb_wb2axi.sv */
// Wishbone to AXI bridge testbench
`timescale 1ns/1ps
`include "wb2axi_defs.svh"

module tb_wb2axi;
	import wb2axi_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int OPS_PER_TEST = 16;
	localparam int OP_CYCLES = 200;
	localparam int CLK_NS = 4;
	localparam addr_t ERR_BASE = 32'h8000_0000;

	// One Wishbone response, expected or seen
	typedef struct packed {
		logic err;
		logic rd;
		data_t data;
	} rsp_t;

	logic clk, rst_n, hold_resp;
	logic wb_cyc, wb_stb, wb_stall, wb_ack, wb_err;
	wb_req_t wb_req;
	data_t wb_rdata;
	axi_aw_t aw, ar;
	axi_w_t w;
	axi_b_t b;
	axi_r_t r;
	logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
	logic b_valid, b_ready, r_valid, r_ready;
	logic mem_busy, mix_err, field_err;

	rsp_t exp_q[$];
	rsp_t got_q[$];
	data_t shadow [addr_t];
	int err_cnt, chk_cnt;

	tb_clk_gen u_clk (.clk(clk));

	wb2axi_top u_dut (
		.aclk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_req(wb_req), .wb_stall(wb_stall),
		.wb_ack(wb_ack), .wb_err(wb_err), .wb_rdata(wb_rdata),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.b(b), .b_valid(b_valid), .b_ready(b_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready)
	);

	tb_axi_mem u_mem (
		.clk(clk), .rst_n(rst_n), .hold_resp(hold_resp),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.b(b), .b_valid(b_valid), .b_ready(b_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.busy(mem_busy), .mix_err(mix_err), .field_err(field_err)
	);

	//////////////////////////////////////////////////
	// Reference model and response capture
	//////////////////////////////////////////////////

	// Initial memory contents, a pattern of the full address
	function automatic data_t fill_pattern(input addr_t a);
		return {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
	endfunction

	function automatic data_t expected_word(input addr_t k);
		if (shadow.exists(k)) begin
			return shadow[k];
		end
		return fill_pattern(k);
	endfunction

	// Ack and err last one cycle, so each shows once here
	always @(negedge clk) begin
		rsp_t seen;
		if (rst_n && (wb_ack || wb_err)) begin
			seen.err = wb_err;
			seen.rd = 1'b0;
			seen.data = wb_rdata;
			got_q.push_back(seen);
			assert (!(wb_ack && wb_err)) else begin
				$display("FAIL %0t: ack and err high together", $time);
				err_cnt++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus driver tasks
	//////////////////////////////////////////////////

	// Entered and left on a falling edge, stb low on return
	task automatic issue_req(input logic we, input addr_t addr, input data_t data,
		input sel_t sel, input int max_wait, output logic accepted);
		rsp_t e;
		addr_t k;
		data_t word;
		int waited;
		accepted = 1'b0;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_req.we = we;
		wb_req.addr = addr;
		wb_req.data = data;
		wb_req.sel = sel;
		while (!accepted && waited < max_wait) begin
			#1;
			accepted = !wb_stall;
			@(negedge clk);
			waited++;
		end
		wb_stb = 1'b0;
		if (accepted) begin
			k = addr & ~addr_t'(3);
			// Byte lanes merged by sel, error region never written
			if (we && k < ERR_BASE) begin
				word = expected_word(k);
				for (int i = 0; i < 4; i++) begin
					if (sel[i]) begin
						word[8*i +: 8] = data[8*i +: 8];
					end
				end
				shadow[k] = word;
			end
			e.err = (k >= ERR_BASE);
			e.rd = !we;
			e.data = expected_word(k);
			exp_q.push_back(e);
		end
	endtask

	task automatic issue(input logic we, input addr_t addr, input data_t data, input sel_t sel);
		logic ok;
		issue_req(we, addr, data, sel, OP_CYCLES, ok);
		assert (ok) else begin
			$display("Request to %h was not accepted within %0d cycles", addr, OP_CYCLES);
			err_cnt++;
		end
	endtask

	task automatic end_cycle();
		wb_cyc = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_resp(input rsp_t e, input rsp_t got);
		chk_cnt++;
		assert (got.err == e.err) else begin
			$display("FAIL %0t: expected %s, got %s", $time,
				e.err ? "err" : "ack", got.err ? "err" : "ack");
			err_cnt++;
		end
		if (e.rd && !e.err) begin
			assert (got.data == e.data) else begin
				$display("FAIL %0t: read data %h, expected %h", $time, got.data, e.data);
				err_cnt++;
			end
		end
	endtask

	// Waits for every expected response, then compares in order
	task automatic drain_and_check();
		int waited;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < OP_CYCLES * OPS_PER_TEST) begin
			@(negedge clk);
			waited++;
		end
		// Room for a surplus response to show up
		repeat (3) @(negedge clk);
		chk_cnt++;
		assert (got_q.size() == exp_q.size()) else begin
			$display("Response count wrong at %0t: %0d expected, %0d seen",
				$time, exp_q.size(), got_q.size());
			err_cnt++;
		end
		while (exp_q.size() != 0 && got_q.size() != 0) begin
			check_resp(exp_q.pop_front(), got_q.pop_front());
		end
		exp_q.delete();
		got_q.delete();
		assert (!mix_err) else begin
			$display("Read and write were outstanding at the same time");
			err_cnt++;
		end
		assert (!field_err) else begin
			$display("AXI request carried wrong fixed fields");
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int base);
		$display("%-20s %s, %0d errors", name, (err_cnt == base) ? "passed" : "failed",
			err_cnt - base);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_single_rw();
		int base;
		base = err_cnt;
		issue(1'b1, 32'h0000_0100, 32'hDEAD_BEEF, 4'b0110);
		issue(1'b0, 32'h0000_0100, '0, 4'hF);
		drain_and_check();
		end_cycle();
		report_test("single write/read", base);
	endtask

	task automatic test_pipelined();
		addr_t addrs [8];
		int base;
		base = err_cnt;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 32'h0000_1000 | ($urandom & 32'h0000_0FFC);
			issue(1'b1, addrs[i], $urandom, sel_t'($urandom_range(1, 15)));
		end
		for (int i = 0; i < 8; i++) begin
			issue(1'b0, addrs[i], '0, 4'hF);
		end
		drain_and_check();
		end_cycle();
		report_test("pipelined burst", base);
	endtask

	task automatic test_error_region();
		int base;
		base = err_cnt;
		issue(1'b1, 32'h7FFF_FFF8, 32'h1111_2222, 4'hF);
		issue(1'b1, 32'h7FFF_FFFC, 32'h3333_4444, 4'hF);
		issue(1'b1, 32'h8000_0000, 32'h5555_6666, 4'hF);
		issue(1'b0, 32'h8000_0000, '0, 4'hF);
		issue(1'b0, 32'h8000_0004, '0, 4'hF);
		issue(1'b0, 32'h7FFF_FFF8, '0, 4'hF);
		issue(1'b0, 32'h7FFF_FFFC, '0, 4'hF);
		drain_and_check();
		end_cycle();
		report_test("error region", base);
	endtask

	task automatic test_dir_switch();
		addr_t a;
		int base;
		base = err_cnt;
		// Each read needs the write before it drained first
		for (int i = 0; i < 6; i++) begin
			a = 32'h0000_2000 | ($urandom & 32'h0000_00FC);
			issue(1'b1, a, $urandom, 4'hF);
			issue(1'b0, a, '0, 4'hF);
		end
		drain_and_check();
		end_cycle();
		report_test("direction switch", base);
	endtask

	task automatic test_abort();
		int base;
		int waited;
		base = err_cnt;
		hold_resp = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 3; i++) begin
			issue(1'b0, 32'h0000_3000 + 4 * i, '0, 4'hF);
		end
		// Drop cyc with all three responses still due
		wb_cyc = 1'b0;
		hold_resp = 1'b0;
		waited = 0;
		while (mem_busy && waited < OP_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		repeat (3) @(negedge clk);
		chk_cnt++;
		assert (!mem_busy) else begin
			$display("Slave still had transactions in flight at %0t after abort", $time);
			err_cnt++;
		end
		assert (got_q.size() == 0) else begin
			$display("FAIL %0t: %0d responses seen after cyc dropped", $time, got_q.size());
			err_cnt++;
		end
		exp_q.delete();
		got_q.delete();
		issue(1'b1, 32'h0000_3100, 32'hCAFE_F00D, 4'hF);
		issue(1'b0, 32'h0000_3100, '0, 4'hF);
		drain_and_check();
		end_cycle();
		report_test("abort", base);
	endtask

	task automatic test_out_limit();
		logic ok;
		int n_acc;
		int base;
		base = err_cnt;
		n_acc = 0;
		hold_resp = 1'b1;
		@(negedge clk);
		for (int i = 0; i < `WB2AXI_MAX_OUT + 2; i++) begin
			issue_req(1'b0, 32'h0000_4000 + 4 * i, '0, 4'hF, 40, ok);
			if (ok) begin
				n_acc++;
			end
		end
		chk_cnt++;
		assert (n_acc == `WB2AXI_MAX_OUT) else begin
			$display("FAIL %0t: %0d requests accepted, limit is %0d", $time, n_acc,
				`WB2AXI_MAX_OUT);
			err_cnt++;
		end
		hold_resp = 1'b0;
		drain_and_check();
		end_cycle();
		report_test("outstanding limit", base);
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(46));
		err_cnt = 0;
		chk_cnt = 0;
		rst_n = 1'b0;
		hold_resp = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_req = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_single_rw();
		test_pipelined();
		test_error_region();
		test_dir_switch();
		test_abort();
		test_out_limit();
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Bound from test count, ops per test and cycles per op
	initial begin
		#(NUM_TESTS * OPS_PER_TEST * OP_CYCLES * CLK_NS);
		$display("Watchdog expired, the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* wb2axi_top.f */
+incdir+.
wb2axi_pkg.sv
wb2axi_ctrl.sv
axi_req_issue.sv
axi_resp_return.sv
wb2axi_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
tb_wb2axi.sv
